// File: rtl/snn_cfg_pkg.sv
package snn_cfg_pkg;

    typedef logic signed [31:0] value_t;   // voltage, current, threshold
    typedef logic [31:0] count_t;
    typedef logic [15:0] host_word_t;

    // values loaded at reset
    localparam value_t I_DEFAULT      = 32'sd10240;
    localparam value_t THRESH_DEFAULT = 32'sd1 <<< 20;

    // neuron update: v += drive - (v >>> LEAK_SHIFT)
    localparam int LEAK_SHIFT = 4;

    // synapse: per presynaptic spike weight and per step decay
    localparam value_t SYN_WEIGHT = 32'sd4096;
    localparam int SYN_DECAY_SHIFT = 1;

    // galois lfsr for current noise
    localparam logic [31:0] LFSR_SEED = 32'h1;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int NOISE_BITS = 10;   // low current bits replaced by noise

endpackage

// File: rtl/snn_map_pkg.sv
package snn_map_pkg;

    typedef logic [7:0] host_addr_t;

    localparam host_addr_t ADDR_CTRL     = 8'h00;
    localparam host_addr_t ADDR_STAGE_LO = 8'h01;
    localparam host_addr_t ADDR_STAGE_HI = 8'h02;
    localparam host_addr_t ADDR_TRIG     = 8'h50;

    // read-back, low half then high half
    localparam host_addr_t ADDR_I_LO    = 8'h10;
    localparam host_addr_t ADDR_I_HI    = 8'h11;
    localparam host_addr_t ADDR_TH_LO   = 8'h12;
    localparam host_addr_t ADDR_TH_HI   = 8'h13;
    localparam host_addr_t ADDR_SYN_LO  = 8'h22;
    localparam host_addr_t ADDR_SYN_HI  = 8'h23;
    localparam host_addr_t ADDR_PRE_LO  = 8'h26;
    localparam host_addr_t ADDR_PRE_HI  = 8'h27;
    localparam host_addr_t ADDR_POST_LO = 8'h28;
    localparam host_addr_t ADDR_POST_HI = 8'h29;

    localparam int TRIG_STEP    = 0;
    localparam int TRIG_LOAD_I  = 6;
    localparam int TRIG_LOAD_TH = 7;
    localparam int CTRL_NOISE   = 15;

endpackage

// File: rtl/state_if.sv
interface state_if #(
    parameter int NN = 8
);
    import snn_cfg_pkg::*;

    logic req;
    logic we;
    logic [$clog2(2*NN)-1:0] addr;
    value_t wdata;
    value_t rdata;   // valid the cycle after a read grant
    logic gnt;

    modport client (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

// File: rtl/host_regs.sv
module host_regs (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     host_wr,
    input  snn_map_pkg::host_addr_t  host_addr,
    input  snn_cfg_pkg::host_word_t  host_wdata,
    output snn_cfg_pkg::host_word_t  host_rdata,
    output snn_cfg_pkg::value_t      current,
    output snn_cfg_pkg::value_t      threshold,
    output logic                     noise_en,
    output logic                     step_go,
    input  logic                     pre_spike,
    input  logic                     post_spike,
    input  snn_cfg_pkg::value_t      syn_current,
    input  logic                     busy
);
    import snn_cfg_pkg::*;
    import snn_map_pkg::*;

    host_word_t ctrl;
    host_word_t stage_lo;
    host_word_t stage_hi;
    count_t pre_cnt;
    count_t post_cnt;
    logic wr_trig;

    assign wr_trig = host_wr && (host_addr == ADDR_TRIG);
    assign noise_en = ctrl[CTRL_NOISE];

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            ctrl <= '0;
            current <= I_DEFAULT;
            threshold <= THRESH_DEFAULT;
            step_go <= 1'b0;
            pre_cnt <= '0;
            post_cnt <= '0;
        end
        else
        begin
            // second trigger right behind the first must not slip past busy
            step_go <= wr_trig && host_wdata[TRIG_STEP] && !busy && !step_go;
            if (host_wr && host_addr == ADDR_CTRL)
                ctrl <= host_wdata;
            if (wr_trig && host_wdata[TRIG_LOAD_I])
                current <= {stage_hi, stage_lo};
            if (wr_trig && host_wdata[TRIG_LOAD_TH])
                threshold <= {stage_hi, stage_lo};
            if (pre_spike)
                pre_cnt <= pre_cnt + 1'b1;
            if (post_spike)
                post_cnt <= post_cnt + 1'b1;
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (host_wr && host_addr == ADDR_STAGE_LO)
            stage_lo <= host_wdata;
        if (host_wr && host_addr == ADDR_STAGE_HI)
            stage_hi <= host_wdata;
        case (host_addr)   // registered read mux
            ADDR_CTRL:     host_rdata <= ctrl;
            ADDR_STAGE_LO: host_rdata <= stage_lo;
            ADDR_STAGE_HI: host_rdata <= stage_hi;
            ADDR_I_LO:     host_rdata <= current[15:0];
            ADDR_I_HI:     host_rdata <= current[31:16];
            ADDR_TH_LO:    host_rdata <= threshold[15:0];
            ADDR_TH_HI:    host_rdata <= threshold[31:16];
            ADDR_SYN_LO:   host_rdata <= syn_current[15:0];
            ADDR_SYN_HI:   host_rdata <= syn_current[31:16];
            ADDR_PRE_LO:   host_rdata <= pre_cnt[15:0];
            ADDR_PRE_HI:   host_rdata <= pre_cnt[31:16];
            ADDR_POST_LO:  host_rdata <= post_cnt[15:0];
            ADDR_POST_HI:  host_rdata <= post_cnt[31:16];
            default:       host_rdata <= '0;
        endcase
    end

    // a step start is only accepted while the core is idle
    a_go_idle: assert property (@(posedge ep50trig) disable iff (reset_global)
        step_go |-> !busy);

endmodule

// File: rtl/noise_lfsr.sv
module noise_lfsr (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 advance,
    input  logic                 noise_en,
    input  snn_cfg_pkg::value_t  current_in,
    output snn_cfg_pkg::value_t  current_out
);
    import snn_cfg_pkg::*;

    logic [31:0] lfsr;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            lfsr <= LFSR_SEED;
        else if (advance)
        begin
            if (lfsr[0])
                lfsr <= (lfsr >> 1) ^ LFSR_TAPS;
            else
                lfsr <= lfsr >> 1;
        end
    end

    assign current_out = noise_en ? {current_in[31:NOISE_BITS], lfsr[NOISE_BITS-1:0]}
                                  : current_in;

endmodule

// File: rtl/lif_population.sv
module lif_population #(
    parameter int NN   = 8,
    parameter int BASE = 0   // 0 for pre, NN for post
) (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 start,
    input  snn_cfg_pkg::value_t  drive,
    input  snn_cfg_pkg::value_t  threshold,
    state_if.client              mem,
    output logic                 spike,
    output logic                 advance,
    output logic                 done
);
    import snn_cfg_pkg::*;

    localparam int AW = $clog2(2*NN);

    typedef enum logic [1:0] {IDLE, RD, CALC, WR} state_t;

    state_t state;
    logic [AW-1:0] idx;
    value_t v_next;
    value_t wr_val;
    logic fire;

    // leaky integrate, arithmetic shift keeps the sign
    assign v_next = mem.rdata + drive - (mem.rdata >>> LEAK_SHIFT);
    assign fire = (v_next >= threshold);

    assign mem.req = (state == RD) || (state == WR);
    assign mem.we = (state == WR);
    assign mem.addr = AW'(BASE) + idx;
    assign mem.wdata = wr_val;

    always_ff @(posedge ep50trig)
    begin
        if (state == CALC)
            wr_val <= fire ? '0 : v_next;   // reset to zero on spike
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state <= IDLE;
            idx <= '0;
            spike <= 1'b0;
            advance <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            spike <= 1'b0;
            advance <= 1'b0;
            done <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (start)
                    begin
                        idx <= '0;
                        state <= RD;
                    end
                end
                RD:
                begin
                    if (mem.gnt)
                        state <= CALC;
                end
                CALC:
                begin
                    spike <= fire;
                    advance <= 1'b1;
                    state <= WR;
                end
                WR:
                begin
                    if (mem.gnt)
                    begin
                        if (idx == AW'(NN - 1))
                        begin
                            done <= 1'b1;
                            state <= IDLE;
                        end
                        else
                        begin
                            idx <= idx + 1'b1;
                            state <= RD;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // grants only come while this population asks
    a_gnt_req: assert property (@(posedge ep50trig) disable iff (reset_global)
        mem.gnt |-> mem.req);

endmodule

// File: rtl/state_arbiter.sv
module state_arbiter #(
    parameter int NN = 8
) (
    input  logic       ep50trig,
    input  logic       reset_global,
    state_if.arbiter   pre_mem,
    state_if.arbiter   post_mem,
    output logic       clearing
);
    import snn_cfg_pkg::*;

    localparam int AW = $clog2(2*NN);

    value_t vmem [2*NN];
    value_t rd_q;
    logic [AW-1:0] clr_idx;
    logic pre_gnt;
    logic post_gnt;
    logic prio_post;   // post wins the next tie

    always_comb
    begin
        pre_gnt = 1'b0;
        post_gnt = 1'b0;
        if (!clearing)
        begin
            if (pre_mem.req && (!post_mem.req || !prio_post))
                pre_gnt = 1'b1;
            else if (post_mem.req)
                post_gnt = 1'b1;
        end
    end

    assign pre_mem.gnt = pre_gnt;
    assign post_mem.gnt = post_gnt;
    assign pre_mem.rdata = rd_q;
    assign post_mem.rdata = rd_q;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            clearing <= 1'b1;
            clr_idx <= '0;
            prio_post <= 1'b0;
        end
        else
        begin
            if (clearing)
            begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == AW'(2*NN - 1))
                    clearing <= 1'b0;
            end
            if (pre_gnt)
                prio_post <= 1'b1;
            else if (post_gnt)
                prio_post <= 1'b0;
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (clearing)
            vmem[clr_idx] <= '0;   // sweep after reset
        else if (pre_gnt && pre_mem.we)
            vmem[pre_mem.addr] <= pre_mem.wdata;
        else if (post_gnt && post_mem.we)
            vmem[post_mem.addr] <= post_mem.wdata;
        if (pre_gnt)
            rd_q <= vmem[pre_mem.addr];
        else if (post_gnt)
            rd_q <= vmem[post_mem.addr];
    end

    // round robin: a client passed over with its request up wins the next cycle
    a_rr_pre: assert property (@(posedge ep50trig) disable iff (reset_global)
        pre_mem.req && post_mem.gnt |=> pre_mem.gnt);
    a_rr_post: assert property (@(posedge ep50trig) disable iff (reset_global)
        post_mem.req && pre_mem.gnt |=> post_mem.gnt);

endmodule

// File: rtl/synapse.sv
module synapse (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 pre_spike,
    input  logic                 step_done,
    output snn_cfg_pkg::value_t  syn_current
);
    import snn_cfg_pkg::*;

    count_t spk_cnt;   // presynaptic spikes seen this step
    value_t decayed;
    value_t added;

    assign decayed = syn_current - (syn_current >>> SYN_DECAY_SHIFT);
    assign added = value_t'(spk_cnt) * SYN_WEIGHT;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            spk_cnt <= '0;
            syn_current <= '0;
        end
        else if (step_done)
        begin
            // populations are idle here, so no spike is lost
            syn_current <= decayed + added;
            spk_cnt <= '0;
        end
        else if (pre_spike)
            spk_cnt <= spk_cnt + 1'b1;
    end

endmodule

// File: rtl/snn_top.sv
module snn_top #(
    parameter int NN = 8
) (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     host_wr,
    input  snn_map_pkg::host_addr_t  host_addr,
    input  snn_cfg_pkg::host_word_t  host_wdata,
    output snn_cfg_pkg::host_word_t  host_rdata,
    output logic                     busy,
    output logic                     step_done,
    output logic                     pre_spike,
    output logic                     post_spike
);
    import snn_cfg_pkg::*;

    value_t current;
    value_t threshold;
    value_t noisy_current;
    value_t syn_current;
    logic noise_en;
    logic step_go;
    logic clearing;
    logic pre_advance;
    logic pre_done;
    logic post_done;
    logic pre_seen;
    logic post_seen;
    logic busy_q;

    state_if #(.NN(NN)) pre_bus ();
    state_if #(.NN(NN)) post_bus ();

    host_regs u_regs (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .host_wr(host_wr), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .current(current), .threshold(threshold),
        .noise_en(noise_en), .step_go(step_go),
        .pre_spike(pre_spike), .post_spike(post_spike),
        .syn_current(syn_current), .busy(busy)
    );

    noise_lfsr u_noise (
        .ep50trig(ep50trig), .reset_global(reset_global), .advance(pre_advance),
        .noise_en(noise_en), .current_in(current), .current_out(noisy_current)
    );

    lif_population #(.NN(NN), .BASE(0)) pre_pop (
        .ep50trig(ep50trig), .reset_global(reset_global), .start(step_go),
        .drive(noisy_current), .threshold(threshold), .mem(pre_bus),
        .spike(pre_spike), .advance(pre_advance), .done(pre_done)
    );

    // syn_current only moves at step_done, so it is constant over a step
    lif_population #(.NN(NN), .BASE(NN)) post_pop (
        .ep50trig(ep50trig), .reset_global(reset_global), .start(step_go),
        .drive(syn_current), .threshold(threshold), .mem(post_bus),
        .spike(post_spike), .advance(), .done(post_done)
    );

    state_arbiter #(.NN(NN)) u_arb (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .pre_mem(pre_bus), .post_mem(post_bus), .clearing(clearing)
    );

    synapse u_syn (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .pre_spike(pre_spike), .step_done(step_done), .syn_current(syn_current)
    );

    assign busy = busy_q || clearing;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            busy_q <= 1'b0;
            pre_seen <= 1'b0;
            post_seen <= 1'b0;
            step_done <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            if (step_go)
                busy_q <= 1'b1;
            if (pre_done)
                pre_seen <= 1'b1;
            if (post_done)
                post_seen <= 1'b1;
            if ((pre_done || pre_seen) && (post_done || post_seen))
            begin
                step_done <= 1'b1;   // both populations finished
                busy_q <= 1'b0;
                pre_seen <= 1'b0;
                post_seen <= 1'b0;
            end
        end
    end

endmodule

// File: tb/snn_tb.sv
module snn_tb;
    import snn_cfg_pkg::*;
    import snn_map_pkg::*;

    localparam int NN = 8;
    localparam int K_STEPS = 10;

    localparam logic [2:0] OP_WR     = 3'd0;
    localparam logic [2:0] OP_STEP   = 3'd1;
    localparam logic [2:0] OP_BURST  = 3'd2;   // step trigger repeated while busy
    localparam logic [2:0] OP_RD     = 3'd3;
    localparam logic [2:0] OP_RD_CNT = 3'd4;   // low and high half read back to back

    typedef struct packed {
        logic [2:0] op;
        host_addr_t addr;
        host_word_t data;
        logic [31:0] want;
    } row_t;

    logic ep50trig;
    logic reset_global;
    logic host_wr;
    host_addr_t host_addr;
    host_word_t host_wdata;
    host_word_t host_rdata;
    logic busy;
    logic step_done;
    logic pre_spike;
    logic post_spike;

    row_t rows[$];
    int wd_cycles;
    count_t done_pulses;
    count_t pre_pulses;
    count_t post_pulses;
    logic [31:0] lcg_state;

    // reference model
    value_t m_cur;
    value_t m_th;
    value_t m_syn;
    host_word_t m_ctrl;
    host_word_t m_stage_lo;
    host_word_t m_stage_hi;
    count_t m_pre_cnt;
    count_t m_post_cnt;
    count_t m_steps;
    logic [31:0] m_lfsr;
    value_t m_vpre [NN];
    value_t m_vpost [NN];

    snn_top #(.NN(NN)) dut (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .host_wr(host_wr), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .busy(busy), .step_done(step_done),
        .pre_spike(pre_spike), .post_spike(post_spike)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #20 ep50trig = ~ep50trig;
    end

    always @(negedge ep50trig)
    begin
        if (reset_global)
        begin
            done_pulses <= '0;
            pre_pulses <= '0;
            post_pulses <= '0;
        end
        else
        begin
            if (step_done)
                done_pulses <= done_pulses + 32'd1;
            if (pre_spike)
                pre_pulses <= pre_pulses + 32'd1;
            if (post_spike)
                post_pulses <= post_pulses + 32'd1;
        end
    end

    initial
    begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge ep50trig);
        $display("step never completed");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        else
            return s >> 1;
    endfunction

    // leaky integrate step of one neuron
    function automatic value_t lif_next(input value_t v, input value_t drive);
        return v + drive - (v >>> LEAK_SHIFT);
    endfunction

    function automatic host_word_t model_word(input host_addr_t addr);
        case (addr)
            ADDR_CTRL:     return m_ctrl;
            ADDR_STAGE_LO: return m_stage_lo;
            ADDR_STAGE_HI: return m_stage_hi;
            ADDR_I_LO:     return m_cur[15:0];
            ADDR_I_HI:     return m_cur[31:16];
            ADDR_TH_LO:    return m_th[15:0];
            ADDR_TH_HI:    return m_th[31:16];
            ADDR_SYN_LO:   return m_syn[15:0];
            ADDR_SYN_HI:   return m_syn[31:16];
            default:       return '0;
        endcase
    endfunction

    task automatic model_step();
        value_t drive;
        value_t nxt;
        count_t spikes;
        int i;
        spikes = '0;
        for (i = 0; i < NN; i++)
        begin
            drive = m_cur;
            if (m_ctrl[CTRL_NOISE])
                drive = {m_cur[31:NOISE_BITS], m_lfsr[NOISE_BITS-1:0]};
            m_lfsr = lfsr_next(m_lfsr);   // one advance per pre neuron, noise on or off
            nxt = lif_next(m_vpre[i], drive);
            if (nxt >= m_th)
            begin
                m_vpre[i] = '0;
                spikes = spikes + 32'd1;
            end
            else
                m_vpre[i] = nxt;
        end
        for (i = 0; i < NN; i++)
        begin
            nxt = lif_next(m_vpost[i], m_syn);   // synaptic current of step start
            if (nxt >= m_th)
            begin
                m_vpost[i] = '0;
                m_post_cnt = m_post_cnt + 32'd1;
            end
            else
                m_vpost[i] = nxt;
        end
        m_pre_cnt = m_pre_cnt + spikes;
        m_syn = m_syn - (m_syn >>> SYN_DECAY_SHIFT) + value_t'(spikes) * SYN_WEIGHT;
        m_steps = m_steps + 32'd1;
    endtask

    task automatic add_row(input logic [2:0] op, input host_addr_t addr,
                           input host_word_t data, input logic [31:0] want);
        row_t r;
        r.op = op;
        r.addr = addr;
        r.data = data;
        r.want = want;
        rows.push_back(r);
    endtask

    task automatic add_wr(input host_addr_t addr, input host_word_t data);
        if (addr == ADDR_CTRL)
            m_ctrl = data;
        if (addr == ADDR_STAGE_LO)
            m_stage_lo = data;
        if (addr == ADDR_STAGE_HI)
            m_stage_hi = data;
        if (addr == ADDR_TRIG && data[TRIG_LOAD_I])
            m_cur = {m_stage_hi, m_stage_lo};
        if (addr == ADDR_TRIG && data[TRIG_LOAD_TH])
            m_th = {m_stage_hi, m_stage_lo};
        add_row(OP_WR, addr, data, '0);
    endtask

    task automatic add_load(input int trig_bit, input value_t value);
        add_wr(ADDR_STAGE_LO, value[15:0]);
        add_wr(ADDR_STAGE_HI, value[31:16]);
        add_wr(ADDR_TRIG, host_word_t'(16'd1 << trig_bit));
    endtask

    task automatic add_step(input logic burst);
        model_step();
        add_row(burst ? OP_BURST : OP_STEP, ADDR_TRIG, 16'h0001, '0);
    endtask

    task automatic add_rd(input host_addr_t addr);
        add_row(OP_RD, addr, '0, {16'h0000, model_word(addr)});
    endtask

    task automatic add_status();
        add_rd(ADDR_SYN_LO);
        add_rd(ADDR_SYN_HI);
        add_row(OP_RD_CNT, ADDR_PRE_LO, '0, m_pre_cnt);
        add_row(OP_RD_CNT, ADDR_POST_LO, '0, m_post_cnt);
    endtask

    task automatic build_table();
        value_t cur;
        int i;
        add_rd(ADDR_I_LO);
        add_rd(ADDR_I_HI);
        add_rd(ADDR_TH_LO);
        add_rd(ADDR_TH_HI);
        add_status();
        // staging alone leaves current and threshold alone
        add_wr(ADDR_STAGE_LO, 16'h1234);
        add_wr(ADDR_STAGE_HI, 16'h0002);
        add_rd(ADDR_I_LO);
        add_rd(ADDR_TH_HI);
        add_wr(ADDR_TRIG, host_word_t'(16'd1 << TRIG_LOAD_I));
        add_rd(ADDR_I_LO);
        add_rd(ADDR_I_HI);
        add_rd(ADDR_TH_LO);
        add_load(TRIG_LOAD_TH, 32'sd150000);
        add_rd(ADDR_TH_LO);
        add_rd(ADDR_TH_HI);
        add_load(TRIG_LOAD_I, '0);   // silent network
        for (i = 0; i < 3; i++)
            add_step(1'b0);
        add_status();
        lcg_state = lcg_next(lcg_state);
        cur = value_t'(32'd20000 + (lcg_state >> 16) % 32'd30000);
        add_load(TRIG_LOAD_I, cur);
        for (i = 0; i < K_STEPS; i++)
            add_step(1'b0);
        add_status();
        add_wr(ADDR_CTRL, host_word_t'(16'd1 << CTRL_NOISE));
        lcg_state = lcg_next(lcg_state);
        cur = value_t'(32'd20000 + (lcg_state >> 16) % 32'd30000);
        add_load(TRIG_LOAD_I, cur);
        for (i = 0; i < K_STEPS; i++)
            add_step(1'b0);
        add_status();
        add_rd(ADDR_CTRL);
        add_step(1'b1);
        add_step(1'b1);
        add_status();
    endtask

    task automatic check_word(input host_word_t got, input host_word_t want, input string what);
        if (got !== want)
        begin
            $display("ERR %0t %s: got %04h expected %04h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "read-back mismatch");
        end
    endtask

    task automatic check_count(input count_t got, input count_t want, input string what);
        if (got !== want)
        begin
            $display("ERR %0t %s: got %0d expected %0d", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want)
        begin
            $display("ERR %0t %s: got %b expected %b", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic write_reg(input host_addr_t addr, input host_word_t data);
        host_wr = 1'b1;
        host_addr = addr;
        host_wdata = data;
        @(negedge ep50trig);
        host_wr = 1'b0;
    endtask

    task automatic read_reg(input host_addr_t addr, output host_word_t val);
        host_addr = addr;
        @(negedge ep50trig);
        val = host_rdata;
    endtask

    task automatic run_step(input int n_trig);
        int k;
        while (busy)
            @(negedge ep50trig);
        for (k = 0; k < n_trig; k++)
            write_reg(ADDR_TRIG, 16'h0001);
        @(negedge ep50trig);
        check_flag(busy, 1'b1, "busy after step trigger");
        while (!step_done)
            @(negedge ep50trig);
        check_flag(busy, 1'b0, "busy at step_done");
        @(negedge ep50trig);   // synapse takes its new current on this edge
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        host_word_t lo;
        host_word_t hi;
        string what;
        r = rows[idx];
        what = $sformatf("row %0d addr %02h", idx, r.addr);
        case (r.op)
            OP_WR:    write_reg(r.addr, r.data);
            OP_STEP:  run_step(1);
            OP_BURST: run_step(3);   // two extra triggers fall inside the step
            OP_RD:
            begin
                read_reg(r.addr, lo);
                check_word(lo, r.want[15:0], what);
            end
            OP_RD_CNT:
            begin
                read_reg(r.addr, lo);
                read_reg(host_addr_t'(r.addr + 8'd1), hi);
                check_count({hi, lo}, r.want, what);
            end
            default: ;
        endcase
    endtask

    initial
    begin
        int idx;
        int i;
        reset_global = 1'b1;
        host_wr = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        wd_cycles = 0;
        lcg_state = 32'hd1bf34b4;
        m_cur = I_DEFAULT;
        m_th = THRESH_DEFAULT;
        m_syn = '0;
        m_ctrl = '0;
        m_stage_lo = '0;
        m_stage_hi = '0;
        m_pre_cnt = '0;
        m_post_cnt = '0;
        m_steps = '0;
        m_lfsr = LFSR_SEED;
        for (i = 0; i < NN; i++)
        begin
            m_vpre[i] = '0;
            m_vpost[i] = '0;
        end
        build_table();
        wd_cycles = 16 + 2 * NN + 50 + rows.size() * (20 * NN + 8);
        repeat (16) @(negedge ep50trig);
        reset_global = 1'b0;
        for (idx = 0; idx < rows.size(); idx++)
            apply_row(idx);
        @(negedge ep50trig);
        check_count(done_pulses, m_steps, "step_done pulses");
        check_count(pre_pulses, m_pre_cnt, "pre_spike pulses");
        check_count(post_pulses, m_post_cnt, "post_spike pulses");
        $display("TEST OK");
        $finish;
    end

endmodule

// File: files.f
rtl/snn_cfg_pkg.sv
rtl/snn_map_pkg.sv
rtl/state_if.sv
rtl/host_regs.sv
rtl/noise_lfsr.sv
rtl/lif_population.sv
rtl/state_arbiter.sv
rtl/synapse.sv
rtl/snn_top.sv
tb/snn_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module snn_tb -o snn_sim
./obj_dir/snn_sim
